//--- design/btac_pkg.sv
package btac_pkg;

  // one pc or address word
  localparam int xlen = 32;

  // a table entry packs three words side by side
  localparam int entry_width = 3 * xlen;

  // tag holds the branch pc and sits in the top word
  localparam int entry_tag_lsb = 2 * xlen;

  // target of the jump
  localparam int entry_target_lsb = xlen;

  // pc of the instruction after the branch
  localparam int entry_npc_lsb = 0;

endpackage

//--- design/btb.sv
`timescale 1ns/1ps

module btb #(
  parameter int entries = 64,
  localparam int idx_width = $clog2(entries)
) (
  input  logic                             clock,
  input  logic                             wen,
  input  logic [idx_width-1:0]             waddr,
  input  logic [idx_width-1:0]             raddr,
  input  logic [btac_pkg::entry_width-1:0] wdata,
  output logic [btac_pkg::entry_width-1:0] rdata
);

  logic [btac_pkg::entry_width-1:0] mem [entries];

  // table starts empty, reset never sweeps it
  initial begin
    for (int i = 0; i < entries; i++) begin
      mem[i] = '0;
    end
  end

  // lookup is answered in the same cycle
  assign rdata = mem[raddr];

  always_ff @(posedge clock) begin
    if (wen) begin
      mem[waddr] <= wdata;
    end
  end

endmodule

//--- design/btac_ctrl.sv
`timescale 1ns/1ps

module btac_ctrl #(
  parameter int entries = 64,
  localparam int idx_width = $clog2(entries)
) (
  input  logic                             clock,
  input  logic                             reset,
  input  logic                             clear,

  // fetch side
  input  logic [btac_pkg::xlen-1:0]        get_pc,
  input  logic                             taken,
  input  logic [btac_pkg::xlen-1:0]        taddr,
  input  logic [btac_pkg::xlen-1:0]        tpc,

  // resolved instructions from execute with port 0 first
  input  logic                             upd_jump0,
  input  logic                             upd_branch0,
  input  logic [btac_pkg::xlen-1:0]        upd_pc0,
  input  logic [btac_pkg::xlen-1:0]        upd_addr0,
  input  logic [btac_pkg::xlen-1:0]        upd_npc0,
  input  logic                             upd_jump1,
  input  logic                             upd_branch1,
  input  logic [btac_pkg::xlen-1:0]        upd_pc1,
  input  logic [btac_pkg::xlen-1:0]        upd_addr1,
  input  logic [btac_pkg::xlen-1:0]        upd_npc1,

  // predictions
  output logic                             pred_branch,
  output logic [btac_pkg::xlen-1:0]        pred_baddr,
  output logic [btac_pkg::xlen-1:0]        pred_pc,
  output logic                             pred_miss,
  output logic [btac_pkg::xlen-1:0]        pred_maddr,

  // table port
  output logic                             wen,
  output logic [idx_width-1:0]             waddr,
  output logic [idx_width-1:0]             raddr,
  output logic [btac_pkg::entry_width-1:0] wdata,
  input  logic [btac_pkg::entry_width-1:0] rdata
);

  logic [btac_pkg::xlen-1:0] rd_tag;
  logic [btac_pkg::xlen-1:0] rd_target;
  logic [btac_pkg::xlen-1:0] rd_npc;
  logic                      hit;

  // pending predicted-taken record
  logic                      rec_taken_q;
  logic [btac_pkg::xlen-1:0] rec_taddr_q;
  logic [btac_pkg::xlen-1:0] rec_tpc_q;

  // record as seen this cycle where a new taken input overrides the stored one
  logic                      rec_taken;
  logic [btac_pkg::xlen-1:0] rec_taddr;
  logic [btac_pkg::xlen-1:0] rec_tpc;

  logic                      resolve;

  // lookup

  always_comb begin
    if (clear) begin
      raddr = '0;
    end else begin
      raddr = get_pc[idx_width:1];
    end
  end

  assign rd_tag    = rdata[btac_pkg::entry_tag_lsb +: btac_pkg::xlen];
  assign rd_target = rdata[btac_pkg::entry_target_lsb +: btac_pkg::xlen];
  assign rd_npc    = rdata[btac_pkg::entry_npc_lsb +: btac_pkg::xlen];

  // an all-zero entry was never written
  assign hit = (|rdata) && (rd_tag == get_pc);

  always_comb begin
    pred_branch = 1'b0;
    pred_baddr  = '0;
    pred_pc     = '0;
    if (!clear && hit) begin
      pred_branch = 1'b1;
      pred_baddr  = rd_target;
      pred_pc     = rd_npc;
    end
  end

  // update where port 0 wins when both jump

  always_comb begin
    wen   = 1'b0;
    waddr = '0;
    wdata = '0;
    if (!clear) begin
      if (upd_jump0) begin
        wen   = 1'b1;
        waddr = upd_pc0[idx_width:1];
        wdata[btac_pkg::entry_tag_lsb +: btac_pkg::xlen]    = upd_pc0;
        wdata[btac_pkg::entry_target_lsb +: btac_pkg::xlen] = upd_addr0;
        wdata[btac_pkg::entry_npc_lsb +: btac_pkg::xlen]    = upd_npc0;
      end else if (upd_jump1) begin
        wen   = 1'b1;
        waddr = upd_pc1[idx_width:1];
        wdata[btac_pkg::entry_tag_lsb +: btac_pkg::xlen]    = upd_pc1;
        wdata[btac_pkg::entry_target_lsb +: btac_pkg::xlen] = upd_addr1;
        wdata[btac_pkg::entry_npc_lsb +: btac_pkg::xlen]    = upd_npc1;
      end
    end
  end

  // misprediction check

  always_comb begin
    rec_taken = taken | rec_taken_q;
    rec_taddr = taken ? taddr : rec_taddr_q;
    rec_tpc   = taken ? tpc : rec_tpc_q;
  end

  // any resolution on either port consumes the record
  assign resolve = upd_jump0 | upd_branch0 | upd_jump1 | upd_branch1;

  always_comb begin
    pred_miss  = 1'b0;
    pred_maddr = '0;
    if (!clear) begin
      if (upd_jump0) begin
        pred_maddr = upd_addr0;
        pred_miss  = rec_taken ? (upd_addr0 != rec_taddr) : 1'b1;
      end else if (upd_branch0) begin
        // predicted taken but fell through
        if (rec_taken) begin
          pred_miss  = 1'b1;
          pred_maddr = rec_tpc;
        end
      end else if (upd_jump1) begin
        pred_maddr = upd_addr1;
        pred_miss  = rec_taken ? (upd_addr1 != rec_taddr) : 1'b1;
      end else if (upd_branch1) begin
        if (rec_taken) begin
          pred_miss  = 1'b1;
          pred_maddr = rec_tpc;
        end
      end
    end
  end

  always_ff @(posedge clock) begin
    if (!reset) begin
      rec_taken_q <= 1'b0;
    end else if (clear || resolve) begin
      rec_taken_q <= 1'b0;
    end else begin
      rec_taken_q <= rec_taken;
    end
  end

  // target and pc of the latest taken input
  always_ff @(posedge clock) begin
    if (taken) begin
      rec_taddr_q <= taddr;
      rec_tpc_q   <= tpc;
    end
  end

endmodule

//--- design/btac.sv
`timescale 1ns/1ps

module btac #(
  parameter int entries     = 64,
  parameter bit btac_enable = 1'b1
) (
  input  logic                      clock,
  input  logic                      reset,
  input  logic                      clear,

  input  logic [btac_pkg::xlen-1:0] get_pc,
  input  logic                      taken,
  input  logic [btac_pkg::xlen-1:0] taddr,
  input  logic [btac_pkg::xlen-1:0] tpc,

  input  logic                      upd_jump0,
  input  logic                      upd_branch0,
  input  logic [btac_pkg::xlen-1:0] upd_pc0,
  input  logic [btac_pkg::xlen-1:0] upd_addr0,
  input  logic [btac_pkg::xlen-1:0] upd_npc0,
  input  logic                      upd_jump1,
  input  logic                      upd_branch1,
  input  logic [btac_pkg::xlen-1:0] upd_pc1,
  input  logic [btac_pkg::xlen-1:0] upd_addr1,
  input  logic [btac_pkg::xlen-1:0] upd_npc1,

  output logic                      pred_branch,
  output logic [btac_pkg::xlen-1:0] pred_baddr,
  output logic [btac_pkg::xlen-1:0] pred_pc,
  output logic                      pred_miss,
  output logic [btac_pkg::xlen-1:0] pred_maddr
);

  localparam int idx_width = $clog2(entries);

  if (btac_enable) begin : g_cache

    logic                             wen;
    logic [idx_width-1:0]             waddr;
    logic [idx_width-1:0]             raddr;
    logic [btac_pkg::entry_width-1:0] wdata;
    logic [btac_pkg::entry_width-1:0] rdata;

    btb #(
      .entries (entries)
    ) u_btb (
      .clock (clock),
      .wen   (wen),
      .waddr (waddr),
      .raddr (raddr),
      .wdata (wdata),
      .rdata (rdata)
    );

    btac_ctrl #(
      .entries (entries)
    ) u_ctrl (
      .clock       (clock),
      .reset       (reset),
      .clear       (clear),
      .get_pc      (get_pc),
      .taken       (taken),
      .taddr       (taddr),
      .tpc         (tpc),
      .upd_jump0   (upd_jump0),
      .upd_branch0 (upd_branch0),
      .upd_pc0     (upd_pc0),
      .upd_addr0   (upd_addr0),
      .upd_npc0    (upd_npc0),
      .upd_jump1   (upd_jump1),
      .upd_branch1 (upd_branch1),
      .upd_pc1     (upd_pc1),
      .upd_addr1   (upd_addr1),
      .upd_npc1    (upd_npc1),
      .pred_branch (pred_branch),
      .pred_baddr  (pred_baddr),
      .pred_pc     (pred_pc),
      .pred_miss   (pred_miss),
      .pred_maddr  (pred_maddr),
      .wen         (wen),
      .waddr       (waddr),
      .raddr       (raddr),
      .wdata       (wdata),
      .rdata       (rdata)
    );

  end else begin : g_off

    // no cache built, fetch never sees a prediction or a redirect
    assign pred_branch = 1'b0;
    assign pred_baddr  = '0;
    assign pred_pc     = '0;
    assign pred_miss   = 1'b0;
    assign pred_maddr  = '0;

  end

endmodule

//--- dv/btac_sva.sv
`timescale 1ns/1ps

module btac_sva (
  input logic clock,
  input logic reset,
  input logic clear,
  input logic wen,
  input logic pred_miss,
  input logic pred_branch,
  input logic upd_jump0,
  input logic upd_jump1
);

  // a flush cycle is silent and writes nothing
  a_clear_quiet: assert property (@(posedge clock)
    clear |-> !wen && !pred_miss && !pred_branch)
    else $error("clear high but wen, pred_miss or pred_branch is set");

  // no write or redirect right after reset
  a_reset_quiet: assert property (@(posedge clock)
    !reset |=> !pred_miss && !wen)
    else $error("pred_miss or wen set in the cycle after reset");

  // only a resolved jump writes the table
  a_wen_from_jump: assert property (@(posedge clock)
    wen |-> upd_jump0 || upd_jump1)
    else $error("wen high without a jump on either port");

endmodule

bind btac_ctrl btac_sva u_sva (
  .clock       (clock),
  .reset       (reset),
  .clear       (clear),
  .wen         (wen),
  .pred_miss   (pred_miss),
  .pred_branch (pred_branch),
  .upd_jump0   (upd_jump0),
  .upd_jump1   (upd_jump1)
);

//--- dv/btac_tb.sv
`timescale 1ns/1ps

module btac_tb;

  localparam int entries = 64;
  localparam int idx_width = $clog2(entries);
  // all tests together run well under a thousand cycles
  localparam int watchdog_cycles = 2000;

  logic                      clock;
  logic                      reset;
  logic                      clear;
  logic [btac_pkg::xlen-1:0] get_pc;
  logic                      taken;
  logic [btac_pkg::xlen-1:0] taddr;
  logic [btac_pkg::xlen-1:0] tpc;
  logic                      upd_jump0;
  logic                      upd_branch0;
  logic [btac_pkg::xlen-1:0] upd_pc0;
  logic [btac_pkg::xlen-1:0] upd_addr0;
  logic [btac_pkg::xlen-1:0] upd_npc0;
  logic                      upd_jump1;
  logic                      upd_branch1;
  logic [btac_pkg::xlen-1:0] upd_pc1;
  logic [btac_pkg::xlen-1:0] upd_addr1;
  logic [btac_pkg::xlen-1:0] upd_npc1;
  logic                      pred_branch;
  logic [btac_pkg::xlen-1:0] pred_baddr;
  logic [btac_pkg::xlen-1:0] pred_pc;
  logic                      pred_miss;
  logic [btac_pkg::xlen-1:0] pred_maddr;

  // reference copy of the table
  logic [btac_pkg::entry_width-1:0] ref_tab [entries];

  btac #(
    .entries     (entries),
    .btac_enable (1'b1)
  ) UUT (
    .clock       (clock),
    .reset       (reset),
    .clear       (clear),
    .get_pc      (get_pc),
    .taken       (taken),
    .taddr       (taddr),
    .tpc         (tpc),
    .upd_jump0   (upd_jump0),
    .upd_branch0 (upd_branch0),
    .upd_pc0     (upd_pc0),
    .upd_addr0   (upd_addr0),
    .upd_npc0    (upd_npc0),
    .upd_jump1   (upd_jump1),
    .upd_branch1 (upd_branch1),
    .upd_pc1     (upd_pc1),
    .upd_addr1   (upd_addr1),
    .upd_npc1    (upd_npc1),
    .pred_branch (pred_branch),
    .pred_baddr  (pred_baddr),
    .pred_pc     (pred_pc),
    .pred_miss   (pred_miss),
    .pred_maddr  (pred_maddr)
  );

  initial begin
    clock = 1'b0;
    forever #5 clock = ~clock;
  end

  initial begin
    repeat (watchdog_cycles) @(posedge clock);
    $display("timeout: the tests did not finish within %0d cycles", watchdog_cycles);
    $display("Something failed");
    $fatal(1, "watchdog expired");
  end

  task automatic check_bit(input string name, input logic expected, input logic actual);
    if (actual !== expected) begin
      $display("CHECK FAILED at %0t: %s expected %b actual %b", $time, name, expected, actual);
      $display("Something failed");
      $fatal(1, "mismatch on %s", name);
    end
  endtask

  task automatic check_word(input string name, input logic [btac_pkg::xlen-1:0] expected,
                            input logic [btac_pkg::xlen-1:0] actual);
    if (actual !== expected) begin
      $display("CHECK FAILED at %0t: %s expected %h actual %h", $time, name, expected, actual);
      $display("Something failed");
      $fatal(1, "mismatch on %s", name);
    end
  endtask

  // inputs change 1 ns after the edge, outputs are sampled mid-cycle
  task automatic next_cycle();
    @(posedge clock);
    #1;
  endtask

  task automatic settle();
    #4;
  endtask

  task automatic release_inputs();
    clear       = 1'b0;
    taken       = 1'b0;
    taddr       = '0;
    tpc         = '0;
    upd_jump0   = 1'b0;
    upd_branch0 = 1'b0;
    upd_pc0     = '0;
    upd_addr0   = '0;
    upd_npc0    = '0;
    upd_jump1   = 1'b0;
    upd_branch1 = 1'b0;
    upd_pc1     = '0;
    upd_addr1   = '0;
    upd_npc1    = '0;
  endtask

  function automatic logic [btac_pkg::xlen-1:0] random_pc();
    return $urandom() & 32'hffff_fffe;
  endfunction

  task automatic drive_jump(input bit port, input logic [btac_pkg::xlen-1:0] pc,
                            input logic [btac_pkg::xlen-1:0] addr,
                            input logic [btac_pkg::xlen-1:0] npc);
    if (port == 1'b0) begin
      upd_jump0 = 1'b1;
      upd_pc0   = pc;
      upd_addr0 = addr;
      upd_npc0  = npc;
    end else begin
      upd_jump1 = 1'b1;
      upd_pc1   = pc;
      upd_addr1 = addr;
      upd_npc1  = npc;
    end
  endtask

  task automatic model_write(input logic [btac_pkg::xlen-1:0] pc,
                             input logic [btac_pkg::xlen-1:0] addr,
                             input logic [btac_pkg::xlen-1:0] npc);
    logic [btac_pkg::entry_width-1:0] e;
    e = '0;
    e[btac_pkg::entry_tag_lsb +: btac_pkg::xlen]    = pc;
    e[btac_pkg::entry_target_lsb +: btac_pkg::xlen] = addr;
    e[btac_pkg::entry_npc_lsb +: btac_pkg::xlen]    = npc;
    ref_tab[pc[idx_width:1]] = e;
  endtask

  task automatic check_lookup(input logic [btac_pkg::xlen-1:0] pc);
    logic [btac_pkg::entry_width-1:0] e;
    logic                             hit;
    e   = ref_tab[pc[idx_width:1]];
    hit = (e != '0) && (e[btac_pkg::entry_tag_lsb +: btac_pkg::xlen] == pc);
    check_bit("pred_branch", hit, pred_branch);
    check_word("pred_baddr", hit ? e[btac_pkg::entry_target_lsb +: btac_pkg::xlen] : '0,
               pred_baddr);
    check_word("pred_pc", hit ? e[btac_pkg::entry_npc_lsb +: btac_pkg::xlen] : '0, pred_pc);
  endtask

  task automatic lookup_cycle(input logic [btac_pkg::xlen-1:0] pc);
    next_cycle();
    release_inputs();
    get_pc = pc;
    settle();
    check_lookup(pc);
  endtask

  task automatic jump_cycle(input bit port, input logic [btac_pkg::xlen-1:0] pc,
                            input logic [btac_pkg::xlen-1:0] addr,
                            input logic [btac_pkg::xlen-1:0] npc);
    next_cycle();
    release_inputs();
    drive_jump(port, pc, addr, npc);
    settle();
    // nothing pending here, so every jump redirects
    check_bit("pred_miss", 1'b1, pred_miss);
    check_word("pred_maddr", addr, pred_maddr);
    model_write(pc, addr, npc);
  endtask

  task automatic load_record(input logic [btac_pkg::xlen-1:0] t,
                             input logic [btac_pkg::xlen-1:0] p);
    next_cycle();
    release_inputs();
    taken = 1'b1;
    taddr = t;
    tpc   = p;
    settle();
    check_bit("pred_miss", 1'b0, pred_miss);
  endtask

  task automatic reset_lookups();
    repeat (16) begin
      lookup_cycle(random_pc());
    end
  endtask

  task automatic port0_updates();
    logic [btac_pkg::xlen-1:0] pc;
    repeat (40) begin
      pc = random_pc();
      jump_cycle(1'b0, pc, random_pc(), pc + 32'd4);
      lookup_cycle(pc);
    end
  endtask

  task automatic dual_jump();
    logic [btac_pkg::xlen-1:0] pc0;
    logic [btac_pkg::xlen-1:0] pc1;
    logic [btac_pkg::xlen-1:0] a0;
    repeat (8) begin
      pc0 = random_pc();
      pc1 = random_pc();
      a0  = random_pc();
      next_cycle();
      release_inputs();
      drive_jump(1'b0, pc0, a0, pc0 + 32'd4);
      drive_jump(1'b1, pc1, random_pc(), pc1 + 32'd2);
      settle();
      check_bit("pred_miss", 1'b1, pred_miss);
      check_word("pred_maddr", a0, pred_maddr);
      model_write(pc0, a0, pc0 + 32'd4);
      lookup_cycle(pc0);
      lookup_cycle(pc1);
    end
  endtask

  task automatic alias_overwrite();
    logic [btac_pkg::xlen-1:0] pc;
    logic [btac_pkg::xlen-1:0] other;
    pc    = random_pc();
    // same index, tag differs above the index bits
    other = pc ^ (32'h1 << (idx_width + 1));
    jump_cycle(1'b1, pc, random_pc(), pc + 32'd4);
    lookup_cycle(pc);
    lookup_cycle(other);
    jump_cycle(1'b0, other, random_pc(), other + 32'd4);
    lookup_cycle(other);
    lookup_cycle(pc);
  endtask

  task automatic miss_sequences();
    logic [btac_pkg::xlen-1:0] pc;
    logic [btac_pkg::xlen-1:0] t;
    logic [btac_pkg::xlen-1:0] p;
    pc = random_pc();
    t  = random_pc();
    p  = pc + 32'd4;
    jump_cycle(1'b1, pc, t, p);
    next_cycle();
    release_inputs();
    upd_branch0 = 1'b1;
    upd_pc0     = pc;
    settle();
    check_bit("pred_miss", 1'b0, pred_miss);
    // predicted target confirmed
    load_record(t, p);
    next_cycle();
    release_inputs();
    drive_jump(1'b0, pc, t, p);
    settle();
    check_bit("pred_miss", 1'b0, pred_miss);
    check_word("pred_maddr", t, pred_maddr);
    model_write(pc, t, p);
    load_record(t, p);
    next_cycle();
    release_inputs();
    drive_jump(1'b0, pc, t + 32'd8, p);
    settle();
    check_bit("pred_miss", 1'b1, pred_miss);
    check_word("pred_maddr", t + 32'd8, pred_maddr);
    model_write(pc, t + 32'd8, p);
    // port 0 fall-through is seen before the port 1 jump
    load_record(t, p);
    next_cycle();
    release_inputs();
    upd_branch0 = 1'b1;
    drive_jump(1'b1, pc, t, p);
    settle();
    check_bit("pred_miss", 1'b1, pred_miss);
    check_word("pred_maddr", p, pred_maddr);
    model_write(pc, t, p);
    load_record(t, p);
    repeat (3) begin
      next_cycle();
      release_inputs();
      settle();
      check_bit("pred_miss", 1'b0, pred_miss);
    end
    next_cycle();
    release_inputs();
    upd_branch1 = 1'b1;
    settle();
    check_bit("pred_miss", 1'b1, pred_miss);
    check_word("pred_maddr", p, pred_maddr);
    next_cycle();
    release_inputs();
    upd_branch1 = 1'b1;
    settle();
    check_bit("pred_miss", 1'b0, pred_miss);
    // taken and its resolution arrive together
    next_cycle();
    release_inputs();
    taken = 1'b1;
    taddr = t;
    tpc   = p;
    drive_jump(1'b0, pc, t, p);
    settle();
    check_bit("pred_miss", 1'b0, pred_miss);
    model_write(pc, t, p);
  endtask

  task automatic clear_flush();
    logic [btac_pkg::xlen-1:0] pc_a;
    logic [btac_pkg::xlen-1:0] pc_b;
    logic [btac_pkg::xlen-1:0] t;
    pc_a = random_pc();
    pc_b = random_pc();
    t    = random_pc();
    jump_cycle(1'b0, pc_a, random_pc(), pc_a + 32'd4);
    lookup_cycle(pc_a);
    load_record(t, pc_a + 32'd4);
    next_cycle();
    release_inputs();
    clear  = 1'b1;
    get_pc = pc_a;
    drive_jump(1'b0, pc_b, random_pc(), pc_b + 32'd4);
    settle();
    check_bit("pred_branch", 1'b0, pred_branch);
    check_word("pred_baddr", '0, pred_baddr);
    check_word("pred_pc", '0, pred_pc);
    check_bit("pred_miss", 1'b0, pred_miss);
    check_word("pred_maddr", '0, pred_maddr);
    // table survives the flush, the blocked write never lands
    lookup_cycle(pc_a);
    lookup_cycle(pc_b);
    jump_cycle(1'b0, pc_a, t, pc_a + 32'd4);
  endtask

  initial begin
    void'($urandom(87));
    reset  = 1'b0;
    get_pc = '0;
    release_inputs();
    for (int i = 0; i < entries; i++) begin
      ref_tab[i] = '0;
    end
    repeat (16) @(posedge clock);
    #1;
    reset = 1'b1;
    reset_lookups();
    port0_updates();
    dual_jump();
    alias_overwrite();
    miss_sequences();
    clear_flush();
    next_cycle();
    $display("Everything OK");
    $finish;
  end

endmodule

//--- files.f
design/btac_pkg.sv
design/btb.sv
design/btac_ctrl.sv
design/btac.sv
dv/btac_sva.sv
dv/btac_tb.sv

//--- run.sh
#!/bin/sh
# builds and runs the btac testbench with Verilator

cd "$(dirname "$0")" || exit 1

log=sim.log
rm -rf obj_dir "$log"

verilator --binary --timing --assert \
  --timescale 1ns/1ps \
  --top-module btac_tb \
  -f files.f \
  -o btac_sim
status=$?
if [ $status -ne 0 ]; then
  echo "build failed with status $status"
  exit 1
fi

./obj_dir/btac_sim > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -qx "Everything OK" "$log"; then
  echo "PASS"
  exit 0
else
  echo "FAIL"
  exit 1
fi
